// ==== beam_macros.svh ====
// ---------------------------------------------------------------------------
// 480p scan geometry, sync positions, register map and reset values
// ---------------------------------------------------------------------------
`ifndef BEAM_MACROS_SVH
`define BEAM_MACROS_SVH

// visible area and full scan, pixels and lines
`define H_RES    640
`define V_RES    480
`define H_TOTAL  800
`define V_TOTAL  525

// sync pulses, both active low, inclusive ends
`define HS_START 656
`define HS_END   751
`define VS_START 490
`define VS_END   491

// wishbone word addresses
`define REG_CTRL  0   // enable + size
`define REG_SPEED 1
`define REG_FG    2   // square colour
`define REG_BG    3   // background colour

// values loaded at reset
`define RST_SIZE  32
`define RST_SPEED 4
`define RST_FG    12'hF80   // orange
`define RST_BG    12'h08F   // blue
`endif

// ==== beam_pkg.sv ====
// ---------------------------------------------------------------------------
// shared types: screen coordinate, 12-bit colour, beam configuration
// ---------------------------------------------------------------------------
package beam_pkg;

    // screen coordinate, covers the full 800x525 scan
    typedef logic [9:0] coord_t;

    // 4 bits per channel, r sits in the top nibble
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    // run-time settings from the register block
    // 1 + 10 + 10 + 12 + 12 = 45 bits
    typedef struct packed {
        logic   enable;   // square moves while set
        coord_t size;     // side length in pixels
        coord_t speed;    // pixels per frame
        rgb_t   fg;       // inside square
        rgb_t   bg;       // everything else visible
    } beam_cfg_t;

    // field offsets in the 16-bit register words
    localparam int CTRL_EN_BIT = 15;
    localparam int FIELD_W     = 10;   // size and speed
    localparam int RGB_W       = 12;

    // register data bus width
    localparam int WB_DW = 16;

endpackage

// ==== video_if.sv ====
// ---------------------------------------------------------------------------
// scan bundle: position, syncs, data enable, per-frame tick
// ---------------------------------------------------------------------------
`timescale 1ns/1ns

interface video_if import beam_pkg::*; ();

    coord_t sx;       // horizontal position
    coord_t sy;       // vertical position
    logic   hsync;    // active low
    logic   vsync;    // active low
    logic   de;       // visible area
    logic   animate;  // first cycle of vertical blanking

    // timing generator side
    modport source (output sx, sy, hsync, vsync, de, animate);

    // consumers, mover and painter
    modport sink (input sx, sy, hsync, vsync, de, animate);

endinterface

// ==== display_timings.sv ====
// ---------------------------------------------------------------------------
// 480p scan counters with sync, data enable and animate decode
// ---------------------------------------------------------------------------
`timescale 1ns/1ns
`include "beam_macros.svh"

module display_timings import beam_pkg::*; (
    input  logic clk_pix,
    input  logic arst_n,
    video_if.source vid
);

    coord_t sx;   // column counter
    coord_t sy;   // line counter
    logic   line_end;
    logic   frame_end;

    assign line_end  = (sx == coord_t'(`H_TOTAL - 1));   // last pixel of line
    assign frame_end = (sy == coord_t'(`V_TOTAL - 1));   // last line of frame

    // horizontal wraps at 800, vertical steps on each wrap
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            sx <= '0;
            sy <= '0;
        end else begin
            if (line_end) begin
                sx <= '0;
                sy <= frame_end ? '0 : sy + coord_t'(1);
            end else begin
                sx <= sx + coord_t'(1);
            end
        end
    end

    // everything below is straight decode of the counters
    assign vid.sx = sx;
    assign vid.sy = sy;

    // active low pulses
    assign vid.hsync = ~((sx >= coord_t'(`HS_START)) && (sx <= coord_t'(`HS_END)));
    assign vid.vsync = ~((sy >= coord_t'(`VS_START)) && (sy <= coord_t'(`VS_END)));

    // visible region only
    assign vid.de = (sx < coord_t'(`H_RES)) && (sy < coord_t'(`V_RES));

    // one cycle per frame, first blank line, first pixel
    assign vid.animate = (sy == coord_t'(`V_RES)) && (sx == '0);

endmodule

// ==== beam_regs.sv ====
// ---------------------------------------------------------------------------
// wishbone classic slave, four configuration registers
// ---------------------------------------------------------------------------
`timescale 1ns/1ns
`include "beam_macros.svh"

module beam_regs import beam_pkg::*; (
    input  logic              clk_pix,
    input  logic              arst_n,
    input  logic              wb_cyc,
    input  logic              wb_stb,
    input  logic              wb_we,
    input  logic [1:0]        wb_adr,
    input  logic [WB_DW-1:0]  wb_dat_w,
    output logic [WB_DW-1:0]  wb_dat_r,
    output logic              wb_ack,
    output beam_cfg_t         cfg
);

    logic             req;      // new access this cycle
    logic [WB_DW-1:0] rd_mux;   // read value before the register

    // no second ack while stb stays up after the first
    assign req = wb_cyc & wb_stb & ~wb_ack;

    // ack one cycle after request, always single cycle
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) wb_ack <= 1'b0;
        else         wb_ack <= req;
    end

    // writes land on the same edge that raises ack
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            cfg.enable <= 1'b1;
            cfg.size   <= coord_t'(`RST_SIZE);
            cfg.speed  <= coord_t'(`RST_SPEED);
            cfg.fg     <= rgb_t'(`RST_FG);
            cfg.bg     <= rgb_t'(`RST_BG);
        end else if (req && wb_we) begin
            case (wb_adr)
                2'(`REG_CTRL): begin
                    cfg.enable <= wb_dat_w[CTRL_EN_BIT];
                    cfg.size   <= wb_dat_w[FIELD_W-1:0];
                end
                2'(`REG_SPEED): cfg.speed <= wb_dat_w[FIELD_W-1:0];
                2'(`REG_FG):    cfg.fg    <= wb_dat_w[RGB_W-1:0];   // r in bits 11..8
                default:        cfg.bg    <= wb_dat_w[RGB_W-1:0];
            endcase
        end
    end

    // read layout mirrors the write fields, rest zero
    always_comb begin
        rd_mux = '0;
        case (wb_adr)
            2'(`REG_CTRL): begin
                rd_mux[CTRL_EN_BIT]   = cfg.enable;
                rd_mux[FIELD_W-1:0]   = cfg.size;
            end
            2'(`REG_SPEED): rd_mux[FIELD_W-1:0] = cfg.speed;
            2'(`REG_FG):    rd_mux[RGB_W-1:0]   = cfg.fg;
            default:        rd_mux[RGB_W-1:0]   = cfg.bg;
        endcase
    end

    // read data valid alongside ack
    always_ff @(posedge clk_pix) begin
        if (req) wb_dat_r <= rd_mux;
    end

endmodule

// ==== square_mover.sv ====
// ---------------------------------------------------------------------------
// square position, stepped once per frame in vertical blanking
// ---------------------------------------------------------------------------
`timescale 1ns/1ns
`include "beam_macros.svh"

module square_mover import beam_pkg::*; (
    input  logic      clk_pix,
    input  logic      arst_n,
    video_if.sink     vid,
    input  beam_cfg_t cfg,
    output coord_t    qx,
    output coord_t    qy
);

    logic   step;      // move this cycle
    logic   at_right;  // no room left on this row
    logic   at_bottom; // no room for another row
    coord_t x_lim;
    coord_t y_lim;

    // limits from the full scan, not the visible area
    assign x_lim = coord_t'(`H_TOTAL) - cfg.size;
    assign y_lim = coord_t'(`V_TOTAL) - cfg.size;

    assign at_right  = (qx >= x_lim);
    assign at_bottom = (qy >= y_lim);

    // freeze position while disabled
    assign step = vid.animate & cfg.enable;

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            qx <= '0;   // top left corner
            qy <= '0;
        end else if (step) begin
            if (at_right) begin
                qx <= '0;                                  // back to left edge
                qy <= at_bottom ? '0 : qy + cfg.size;      // next row or top
            end else begin
                qx <= qx + cfg.speed;
            end
        end
    end

endmodule

// ==== beam_painter.sv ====
// ---------------------------------------------------------------------------
// square hit test, colour select, registered sync and colour outputs
// ---------------------------------------------------------------------------
`timescale 1ns/1ns

module beam_painter import beam_pkg::*; (
    input  logic       clk_pix,
    input  logic       arst_n,
    video_if.sink      vid,
    input  beam_cfg_t  cfg,
    input  coord_t     qx,
    input  coord_t     qy,
    output logic       hsync,
    output logic       vsync,
    output logic       de,
    output logic [3:0] red,
    output logic [3:0] green,
    output logic [3:0] blue
);

    logic [10:0] x_end;   // one past right edge, extra bit for overflow
    logic [10:0] y_end;   // one past bottom edge
    logic        q_draw;  // scan inside square
    rgb_t        pix;     // colour before the output register

    assign x_end = {1'b0, qx} + {1'b0, cfg.size};
    assign y_end = {1'b0, qy} + {1'b0, cfg.size};

    // half open box, qx <= sx < qx+size
    assign q_draw = (vid.sx >= qx) && ({1'b0, vid.sx} < x_end)
                 && (vid.sy >= qy) && ({1'b0, vid.sy} < y_end);

    always_comb begin
        if (!vid.de)     pix = '0;        // black in blanking
        else if (q_draw) pix = cfg.fg;
        else             pix = cfg.bg;
    end

    // everything leaves one cycle after the counters
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            hsync <= 1'b1;   // inactive
            vsync <= 1'b1;
            de    <= 1'b0;
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end else begin
            hsync <= vid.hsync;
            vsync <= vid.vsync;
            de    <= vid.de;
            red   <= pix.r;
            green <= pix.g;
            blue  <= pix.b;
        end
    end

endmodule

// ==== beam_top.sv ====
// ---------------------------------------------------------------------------
// beam generator top: timings, registers, mover and painter
// ---------------------------------------------------------------------------
`timescale 1ns/1ns

module beam_top import beam_pkg::*; (
    input  logic        clk_pix,
    input  logic        arst_n,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [1:0]  wb_adr,
    input  logic [15:0] wb_dat_w,
    output logic [15:0] wb_dat_r,
    output logic        wb_ack,
    output logic        hsync,    // active low
    output logic        vsync,    // active low
    output logic        de,
    output logic [3:0]  red,
    output logic [3:0]  green,
    output logic [3:0]  blue
);

    video_if   vid ();   // scan bundle from the counters
    beam_cfg_t cfg;      // live settings
    coord_t    qx;       // square top left
    coord_t    qy;

    display_timings u_timings (
        .clk_pix (clk_pix),
        .arst_n  (arst_n),
        .vid     (vid.source)
    );

    beam_regs u_regs (
        .clk_pix  (clk_pix),
        .arst_n   (arst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .cfg      (cfg)
    );

    square_mover u_mover (
        .clk_pix (clk_pix),
        .arst_n  (arst_n),
        .vid     (vid.sink),
        .cfg     (cfg),
        .qx      (qx),
        .qy      (qy)
    );

    // registered outputs, one cycle behind the counters
    beam_painter u_painter (
        .clk_pix (clk_pix),
        .arst_n  (arst_n),
        .vid     (vid.sink),
        .cfg     (cfg),
        .qx      (qx),
        .qy      (qy),
        .hsync   (hsync),
        .vsync   (vsync),
        .de      (de),
        .red     (red),
        .green   (green),
        .blue    (blue)
    );

endmodule

// ==== beam_checker.sv ====
// ---------------------------------------------------------------------------
// reference model on the top-level ports: scan timing, config, square, pixels
// ---------------------------------------------------------------------------
`timescale 1ns/1ns
`include "beam_macros.svh"

module beam_checker import beam_pkg::*; (
    input logic        clk_pix,
    input logic        arst_n,
    input logic        wb_cyc,
    input logic        wb_stb,
    input logic        wb_we,
    input logic [1:0]  wb_adr,
    input logic [15:0] wb_dat_w,
    input logic        wb_ack,
    input logic        hsync,
    input logic        vsync,
    input logic        de,
    input logic [3:0]  red,
    input logic [3:0]  green,
    input logic [3:0]  blue
);

    localparam int HS_WIDTH     = `HS_END - `HS_START + 1;                  // 96
    localparam int VS_CYCLES    = (`VS_END - `VS_START + 1) * `H_TOTAL;    // 2 lines
    localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;
    localparam int MAX_PRINT    = 20;

    int          errors = 0;
    beam_cfg_t   m_cfg;       // config as written over the bus
    int          px, py;      // output position, rebuilt from de and vsync
    int          qx, qy;      // square model
    int          hs_low, vs_low, frame_len;
    logic        de_q, hs_q, vs_q;
    logic        framed;      // one vsync seen
    logic        pend;        // write waiting for its ack
    logic [1:0]  pend_adr;
    logic [15:0] pend_dat;
    logic        hit;
    rgb_t        exp_rgb;
    rgb_t        got_rgb;

    task automatic mismatch(input string what, input int got, input int exp);
        errors++;
        if (errors <= MAX_PRINT) $display("[ERROR] %s: got %h expected %h", what, got, exp);
    endtask

    always @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            m_cfg.enable = 1'b1;
            m_cfg.size   = 10'(`RST_SIZE);
            m_cfg.speed  = 10'(`RST_SPEED);
            m_cfg.fg     = `RST_FG;
            m_cfg.bg     = `RST_BG;
            px = 0;  py = 0;
            qx = 0;  qy = 0;
            hs_low = 0;  vs_low = 0;  frame_len = 0;
            de_q = 1'b0;  hs_q = 1'b1;  vs_q = 1'b1;
            framed = 1'b0;
            pend   = 1'b0;
        end else begin
            if (pend && wb_ack) begin   // write lands with ack
                case (pend_adr)
                    2'(`REG_CTRL): begin
                        m_cfg.enable = pend_dat[15];
                        m_cfg.size   = pend_dat[9:0];
                    end
                    2'(`REG_SPEED): m_cfg.speed = pend_dat[9:0];
                    2'(`REG_FG):    m_cfg.fg    = pend_dat[11:0];
                    default:        m_cfg.bg    = pend_dat[11:0];
                endcase
            end
            pend     = wb_cyc && wb_stb && wb_we && !wb_ack;   // new request
            pend_adr = wb_adr;
            pend_dat = wb_dat_w;

            got_rgb = {red, green, blue};
            if (de) begin
                hit = (px >= qx) && (px < qx + int'(m_cfg.size))
                   && (py >= qy) && (py < qy + int'(m_cfg.size));
                exp_rgb = hit ? m_cfg.fg : m_cfg.bg;
                if (got_rgb !== exp_rgb)
                    mismatch($sformatf("red/green/blue at x %0d y %0d", px, py),
                             int'(got_rgb), int'(exp_rgb));
                px++;
            end else if (got_rgb !== 12'h000) begin
                mismatch("red/green/blue in blanking", int'(got_rgb), 0);
            end
            if (!de && de_q) begin   // end of a visible line
                if (px != `H_RES) mismatch("de cycles per line", px, `H_RES);
                px = 0;
                py++;
            end

            if (!hsync) hs_low++;
            else if (!hs_q) begin
                if (hs_low != HS_WIDTH) mismatch("hsync low cycles", hs_low, HS_WIDTH);
                hs_low = 0;
            end
            if (!vsync) vs_low++;
            else if (!vs_q) begin
                if (vs_low != VS_CYCLES) mismatch("vsync low cycles", vs_low, VS_CYCLES);
                vs_low = 0;
            end

            frame_len++;
            if (!vsync && vs_q) begin   // frame boundary
                if (py != `V_RES) mismatch("de lines per frame", py, `V_RES);
                if (framed && frame_len != FRAME_CYCLES)
                    mismatch("cycles between vsync pulses", frame_len, FRAME_CYCLES);
                framed    = 1'b1;
                frame_len = 0;
                py        = 0;
                // square steps once per blanking while enabled
                if (m_cfg.enable) begin
                    if (qx >= `H_TOTAL - int'(m_cfg.size)) begin
                        qx = 0;
                        qy = (qy >= `V_TOTAL - int'(m_cfg.size)) ? 0 : qy + int'(m_cfg.size);
                    end else begin
                        qx = (qx + int'(m_cfg.speed)) % 1024;   // 10-bit coordinate
                    end
                end
            end
            de_q = de;
            hs_q = hsync;
            vs_q = vsync;
        end
    end

endmodule

// ==== beam_props.sv ====
// ---------------------------------------------------------------------------
// concurrent checks on wishbone ack and on vsync against data enable
// ---------------------------------------------------------------------------
`timescale 1ns/1ns

module beam_props (
    input logic clk_pix,
    input logic arst_n,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input logic vsync,
    input logic de
);

    int fail_count = 0;   // failed assertions so far

    // single cycle ack pulse
    ack_one_cycle: assert property (@(posedge clk_pix) disable iff (!arst_n)
        wb_ack |=> !wb_ack)
        else begin
            fail_count++;
            $error("wb_ack held for more than one cycle");
        end

    // ack only answers a request
    ack_after_req: assert property (@(posedge clk_pix) disable iff (!arst_n)
        wb_ack |-> $past(wb_cyc && wb_stb))
        else begin
            fail_count++;
            $error("wb_ack without cyc and stb in the cycle before");
        end

    // vertical sync sits in blanking
    no_de_in_vsync: assert property (@(posedge clk_pix) disable iff (!arst_n)
        !vsync |-> !de)
        else begin
            fail_count++;
            $error("de high during vsync pulse");
        end

endmodule

bind beam_top beam_props u_props (
    .clk_pix (clk_pix),
    .arst_n  (arst_n),
    .wb_cyc  (wb_cyc),
    .wb_stb  (wb_stb),
    .wb_ack  (wb_ack),
    .vsync   (vsync),
    .de      (de)
);

// ==== tb_beam.sv ====
// ---------------------------------------------------------------------------
// testbench top with clock, reset, wishbone stimulus table, watchdog and verdict
// ---------------------------------------------------------------------------
`timescale 1ns/1ns
`include "beam_macros.svh"

module tb_beam;

    localparam int CLK_HALF     = 20;                     // 40 ns period
    localparam int RESET_CYCLES = 16;
    localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;    // 420000

    // one wishbone access after the given number of vsync falls
    typedef struct {
        int          frame;
        logic        we;
        logic [1:0]  adr;
        logic [15:0] dat;
        logic [15:0] exp;   // reads only
    } wb_op_t;

    logic        clk_pix;
    logic        arst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [1:0]  wb_adr;
    logic [15:0] wb_dat_w;
    logic [15:0] wb_dat_r;
    logic        wb_ack;
    logic        hsync;
    logic        vsync;
    logic        de;
    logic [3:0]  red;
    logic [3:0]  green;
    logic [3:0]  blue;

    wb_op_t ops[$];
    int     errors;
    int     seed;
    int     last_frame;    // highest frame index in the table
    logic   table_ready;

    beam_top u_dut (
        .clk_pix (clk_pix), .arst_n (arst_n),
        .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we),
        .wb_adr (wb_adr), .wb_dat_w (wb_dat_w), .wb_dat_r (wb_dat_r), .wb_ack (wb_ack),
        .hsync (hsync), .vsync (vsync), .de (de),
        .red (red), .green (green), .blue (blue)
    );

    // reference model on the same ports
    beam_checker u_chk (
        .clk_pix (clk_pix), .arst_n (arst_n),
        .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we),
        .wb_adr (wb_adr), .wb_dat_w (wb_dat_w), .wb_ack (wb_ack),
        .hsync (hsync), .vsync (vsync), .de (de),
        .red (red), .green (green), .blue (blue)
    );

    always #CLK_HALF clk_pix = ~clk_pix;

    task automatic add_op(input int frame, input logic we, input logic [1:0] adr,
                          input logic [15:0] dat, input logic [15:0] exp);
        wb_op_t op;
        op.frame = frame;
        op.we    = we;
        op.adr   = adr;
        op.dat   = dat;
        op.exp   = exp;
        ops.push_back(op);
        if (frame > last_frame) last_frame = frame;
    endtask

    task automatic build_table();
        logic [15:0] fg_val;
        logic [15:0] bg_val;
        fg_val = 16'($random(seed));
        bg_val = 16'($random(seed));
        // reset values
        add_op(1, 1'b0, 2'(`REG_CTRL),  16'h0000, 16'h8020);
        add_op(1, 1'b0, 2'(`REG_SPEED), 16'h0000, 16'h0004);
        add_op(1, 1'b0, 2'(`REG_FG),    16'h0000, 16'h0F80);
        add_op(1, 1'b0, 2'(`REG_BG),    16'h0000, 16'h008F);
        // speed 100 and size 64 with junk in unused bits
        add_op(1, 1'b1, 2'(`REG_SPEED), 16'hFC64, 16'h0000);
        add_op(1, 1'b0, 2'(`REG_SPEED), 16'h0000, 16'h0064);
        add_op(1, 1'b1, 2'(`REG_CTRL),  16'hFC40, 16'h0000);
        add_op(1, 1'b0, 2'(`REG_CTRL),  16'h0000, 16'h8040);
        // square has wrapped to row 64 by now
        add_op(10, 1'b1, 2'(`REG_FG), fg_val, 16'h0000);
        add_op(10, 1'b1, 2'(`REG_BG), bg_val, 16'h0000);
        add_op(10, 1'b0, 2'(`REG_FG), 16'h0000, fg_val & 16'h0FFF);
        add_op(10, 1'b0, 2'(`REG_BG), 16'h0000, bg_val & 16'h0FFF);
        // stop the square so it holds from here
        add_op(11, 1'b1, 2'(`REG_CTRL),  16'h7C40, 16'h0000);
        add_op(11, 1'b0, 2'(`REG_CTRL),  16'h0000, 16'h0040);
        add_op(13, 1'b0, 2'(`REG_SPEED), 16'h0000, 16'h0064);
    endtask

    // classic cycle with the request held one cycle past ack
    task automatic wb_access(input wb_op_t op, output logic [15:0] rdata);
        int waited;
        waited = 0;
        @(negedge clk_pix);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = op.we;
        wb_adr   = op.adr;
        wb_dat_w = op.dat;
        do begin
            @(negedge clk_pix);
            waited++;
        end while (!wb_ack && waited < 16);
        if (!wb_ack) begin
            errors++;
            $display("no ack from the DUT within %0d cycles", waited);
        end else if (waited != 1) begin
            errors++;
            $display("ack came after %0d cycles instead of one", waited);
        end
        rdata = wb_dat_r;   // valid with ack
        // slow master keeps stb up and must not get a second ack
        @(negedge clk_pix);
        if (wb_ack) begin
            errors++;
            $display("second ack while the request was still held");
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    initial begin : watchdog
        wait (table_ready);
        repeat ((last_frame + 2) * FRAME_CYCLES) @(posedge clk_pix);
        $display("timeout: run did not finish within %0d frames", last_frame + 2);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        int          frames_seen;
        logic [15:0] rdata;
        clk_pix     = 1'b0;
        arst_n      = 1'b0;
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_adr      = 2'd0;
        wb_dat_w    = 16'h0000;
        errors      = 0;
        seed        = 32'h687d471e;
        last_frame  = 0;
        frames_seen = 0;
        table_ready = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk_pix);
        arst_n = 1'b1;
        foreach (ops[i]) begin
            while (frames_seen < ops[i].frame) begin
                @(negedge vsync);   // frame boundary
                frames_seen++;
            end
            wb_access(ops[i], rdata);
            if (!ops[i].we && rdata !== ops[i].exp) begin
                errors++;
                $display("[ERROR] wb_dat_r adr %h: got %h expected %h",
                         ops[i].adr, rdata, ops[i].exp);
            end
        end
        // let the last table frame scan out
        while (frames_seen <= last_frame) begin
            @(negedge vsync);
            frames_seen++;
        end
        $display("errors: tb %0d, checker %0d, assertions %0d",
                 errors, u_chk.errors, u_dut.u_props.fail_count);
        if (errors == 0 && u_chk.errors == 0 && u_dut.u_props.fail_count == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+.
beam_pkg.sv
video_if.sv
display_timings.sv
beam_regs.sv
square_mover.sv
beam_painter.sv
beam_top.sv
beam_checker.sv
beam_props.sv
tb_beam.sv

// ==== Makefile ====
# Verilator flow for the beam generator

VERILATOR ?= verilator
FILELIST  ?= verilog.f
TOP       ?= tb_beam
LINT_TOP  ?= beam_top
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Simulation finished: PASS

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(LINT_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
